// File: dummy_insert_top.f
source/dummy_pkg.sv
source/dummy_lfsr.sv
source/dummy_insert_ctrl.sv
source/instr_fifo.sv
source/decode_stage.sv
source/dummy_insert_top.sv
testbench/dummy_insert_checker.sv
testbench/dummy_insert_tb.sv

// File: run.sh
#!/bin/sh
# Compiles the testbench with Verilator and runs the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module dummy_insert_tb \
  -f dummy_insert_top.f \
  -o dummy_insert_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/dummy_insert_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q '^Testbench passed$'; then
  exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

// File: source/decode_stage.sv
////////////////////////////////////////////////////////////
// Decode and execute stage
// Runs every instruction through the ALU
// Registers real results and counts consumed dummies
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module decode_stage
  import dummy_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       in_valid_i,
  output logic                       in_ready_o,
  input  instr_t                     in_instr_i,
  output logic                       res_valid_o,
  input  logic                       res_ready_i,
  output result_t                    res_o,
  output logic [DUMMY_CNT_WIDTH-1:0] dummy_count_o
);

  logic [15:0]                alu_value;
  logic                       in_fire;
  logic                       keep_result;
  logic                       res_valid_q;
  result_t                    res_q;
  logic [DUMMY_CNT_WIDTH-1:0] dummy_cnt_q;

  // The ALU sees dummies exactly like real work so the datapath toggles either way
  always_comb begin
    case (in_instr_i.opcode)
      OP_ADD:  alu_value = in_instr_i.operand_a + in_instr_i.operand_b;
      OP_SUB:  alu_value = in_instr_i.operand_a - in_instr_i.operand_b;
      OP_XOR:  alu_value = in_instr_i.operand_a ^ in_instr_i.operand_b;
      OP_AND:  alu_value = in_instr_i.operand_a & in_instr_i.operand_b;
      default: alu_value = in_instr_i.operand_a;
    endcase
  end

  // Input stalls only while an unread result sits in the output register
  assign in_ready_o  = !res_valid_q || res_ready_i;
  assign in_fire     = in_valid_i && in_ready_o;
  assign keep_result = !in_instr_i.is_dummy && (in_instr_i.opcode != OP_HINT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid_q <= 1'b0;
      dummy_cnt_q <= '0;
    end else begin
      if (res_valid_q && res_ready_i) begin
        res_valid_q <= 1'b0;
      end
      if (in_fire && keep_result) begin
        res_valid_q <= 1'b1;
      end
      // Counter wraps at its full width
      if (in_fire && in_instr_i.is_dummy) begin
        dummy_cnt_q <= dummy_cnt_q + 1'b1;
      end
    end
  end

  // Result payload
  always_ff @(posedge clk) begin
    if (in_fire && keep_result) begin
      res_q.opcode <= in_instr_i.opcode;
      res_q.value  <= alu_value;
    end
  end

  assign res_valid_o   = res_valid_q;
  assign res_o         = res_q;
  assign dummy_count_o = dummy_cnt_q;

endmodule

// File: source/dummy_insert_ctrl.sv
////////////////////////////////////////////////////////////
// Dummy instruction insertion controller
// Passes fetched instructions through to the buffer
// Counts accepted instructions against the LFSR threshold
// Offers a generated dummy when the threshold is exceeded
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dummy_insert_ctrl
  import dummy_pkg::*;
#(
  parameter int CNT_WIDTH = 7
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  xsecure_ctrl_t         xsecure_ctrl_i,
  // Fetch side
  input  logic                  fetch_valid_i,
  output logic                  fetch_ready_o,
  input  instr_t                fetch_instr_i,
  // Buffer side
  output logic                  ins_valid_o,
  input  logic                  ins_ready_i,
  output instr_t                ins_instr_o,
  // LFSR side
  input  logic [5:0]            lfsr_cnt_i,
  input  logic [LFSR_WIDTH-1:0] lfsr_state_i,
  output logic                  lfsr_shift_o
);

  // PASS forwards fetch traffic and INSERT offers a dummy in its place
  typedef enum logic {
    PASS,
    INSERT
  } state_e;

  state_e               state;
  logic                 insert_pending;
  logic                 ins_fire;
  logic                 hint_fire;
  logic [CNT_WIDTH-1:0] cnt_q;
  logic [CNT_WIDTH-1:0] cnt_d;
  instr_t               dummy_instr;
  instr_t               real_instr;

  ////////////////////////////////////////////////////////////
  // Insertion decision
  ////////////////////////////////////////////////////////////

  // The counter and the LFSR both move only on accepted transfers
  // The decision therefore holds steady while an item waits for the buffer
  // It also sees the threshold after a hint has shifted the LFSR
  assign insert_pending = xsecure_ctrl_i.dummy_en &&
                          (cnt_q > CNT_WIDTH'(lfsr_cnt_i));
  assign state          = insert_pending ? INSERT : PASS;

  assign ins_fire  = ins_valid_o && ins_ready_i;
  assign hint_fire = ins_fire && (state == PASS) && (fetch_instr_i.opcode == OP_HINT);

  // Accepted dummies and hints both step the LFSR
  assign lfsr_shift_o = (ins_fire && (state == INSERT)) || hint_fire;

  // Counting is held at zero while insertion is disabled so it cannot run away
  always_comb begin
    cnt_d = cnt_q;
    if (!xsecure_ctrl_i.dummy_en) begin
      cnt_d = '0;
    end else if (ins_fire) begin
      if (state == INSERT) begin
        cnt_d = '0;
      end else begin
        cnt_d = cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Instruction mux
  ////////////////////////////////////////////////////////////

  // Dummy contents come straight from the LFSR state
  // Only the four ALU opcodes are drawn so the dummy always toggles the datapath
  always_comb begin
    dummy_instr           = '0;
    dummy_instr.opcode    = opcode_e'({1'b0, lfsr_state_i[1:0]});
    dummy_instr.operand_a = {lfsr_state_i, lfsr_state_i};
    dummy_instr.operand_b = ~{lfsr_state_i, lfsr_state_i};
    dummy_instr.is_dummy  = 1'b1;
  end

  // Fetched words can never claim to be dummies
  always_comb begin
    real_instr          = fetch_instr_i;
    real_instr.is_dummy = 1'b0;
  end

  always_comb begin
    case (state)
      INSERT: begin
        ins_valid_o   = 1'b1;
        ins_instr_o   = dummy_instr;
        fetch_ready_o = 1'b0;
      end
      default: begin
        ins_valid_o   = fetch_valid_i;
        ins_instr_o   = real_instr;
        fetch_ready_o = ins_ready_i;
      end
    endcase
  end

endmodule

// File: source/dummy_insert_top.sv
////////////////////////////////////////////////////////////
// Top level of the dummy instruction insertion path
// Controller and LFSR feed the FIFO which feeds decode
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dummy_insert_top
  import dummy_pkg::*;
#(
  parameter int                    FIFO_DEPTH = 4,
  parameter int                    CNT_WIDTH  = 7,
  parameter logic [LFSR_WIDTH-1:0] LFSR_SEED  = 8'h5A
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  xsecure_ctrl_t              xsecure_ctrl_i,
  input  logic                       fetch_valid_i,
  output logic                       fetch_ready_o,
  input  instr_t                     fetch_instr_i,
  output logic                       res_valid_o,
  input  logic                       res_ready_i,
  output result_t                    res_o,
  output logic [DUMMY_CNT_WIDTH-1:0] dummy_count_o
);

  ////////////////////////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////////////////////////

  // Controller to FIFO
  logic                  ins_valid;
  logic                  ins_ready;
  instr_t                ins_instr;
  // FIFO to decode
  logic                  buf_valid;
  logic                  buf_ready;
  instr_t                buf_instr;
  // Controller and LFSR
  logic                  lfsr_shift;
  logic [5:0]            lfsr_cnt;
  logic [LFSR_WIDTH-1:0] lfsr_state;

  dummy_insert_ctrl #(
    .CNT_WIDTH (CNT_WIDTH)
  ) ctrl_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .xsecure_ctrl_i (xsecure_ctrl_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_ready_o  (fetch_ready_o),
    .fetch_instr_i  (fetch_instr_i),
    .ins_valid_o    (ins_valid),
    .ins_ready_i    (ins_ready),
    .ins_instr_o    (ins_instr),
    .lfsr_cnt_i     (lfsr_cnt),
    .lfsr_state_i   (lfsr_state),
    .lfsr_shift_o   (lfsr_shift)
  );

  dummy_lfsr #(
    .LFSR_SEED (LFSR_SEED)
  ) lfsr_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .shift_i      (lfsr_shift),
    .dummy_freq_i (xsecure_ctrl_i.dummy_freq),
    .lfsr_cnt_o   (lfsr_cnt),
    .lfsr_state_o (lfsr_state)
  );

  instr_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fifo_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_valid_i (ins_valid),
    .wr_ready_o (ins_ready),
    .wr_instr_i (ins_instr),
    .rd_valid_o (buf_valid),
    .rd_ready_i (buf_ready),
    .rd_instr_o (buf_instr)
  );

  decode_stage decode_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid_i    (buf_valid),
    .in_ready_o    (buf_ready),
    .in_instr_i    (buf_instr),
    .res_valid_o   (res_valid_o),
    .res_ready_i   (res_ready_i),
    .res_o         (res_o),
    .dummy_count_o (dummy_count_o)
  );

endmodule

// File: source/dummy_lfsr.sv
////////////////////////////////////////////////////////////
// Galois LFSR for dummy instruction insertion
// Steps once per shift request
// Provides the masked insertion threshold and raw state bits
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dummy_lfsr
  import dummy_pkg::*;
#(
  parameter logic [LFSR_WIDTH-1:0] LFSR_SEED = 8'h5A
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  shift_i,
  input  logic [1:0]            dummy_freq_i,
  output logic [5:0]            lfsr_cnt_o,
  output logic [LFSR_WIDTH-1:0] lfsr_state_o
);

  logic [LFSR_WIDTH-1:0] state_q;
  logic [LFSR_WIDTH-1:0] state_next;

  // The register shifts right and the polynomial is folded in when a one drops out
  // A nonzero seed keeps the sequence out of the all-zero lock-up state
  always_comb begin
    state_next = state_q >> 1;
    if (state_q[0]) begin
      state_next = state_next ^ LFSR_POLY;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= LFSR_SEED;
    end else if (shift_i) begin
      state_q <= state_next;
    end
  end

  // The threshold only uses as many low bits as the selected frequency allows
  assign lfsr_cnt_o   = state_q[5:0] & FREQ_MASK[dummy_freq_i];
  assign lfsr_state_o = state_q;

endmodule

// File: source/dummy_pkg.sv
////////////////////////////////////////////////////////////
// Shared definitions for the dummy instruction path
// Opcode enum with the hint opcode
// Instruction, result and security control structs
// Threshold mask table and LFSR feedback polynomial
////////////////////////////////////////////////////////////

package dummy_pkg;

  // Width of the insertion LFSR and of the dummy counter in decode
  localparam int LFSR_WIDTH      = 8;
  localparam int DUMMY_CNT_WIDTH = 16;

  // Opcodes carried in the 3-bit opcode field
  // A hint executes as a no-op but still counts as an instruction
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_XOR  = 3'd2,
    OP_AND  = 3'd3,
    OP_HINT = 3'd4
  } opcode_e;

  // One instruction word as it moves from fetch to decode (36 bits)
  typedef struct packed {
    opcode_e     opcode;
    logic [15:0] operand_a;
    logic [15:0] operand_b;
    logic        is_dummy;
  } instr_t;

  // Result of a real ALU instruction (19 bits)
  typedef struct packed {
    opcode_e     opcode;
    logic [15:0] value;
  } result_t;

  // Security control bits for dummy insertion
  typedef struct packed {
    logic       dummy_en;
    logic [1:0] dummy_freq;
  } xsecure_ctrl_t;

  // Threshold masks selected by dummy_freq, index 0 gives the densest insertion
  localparam logic [3:0][5:0] FREQ_MASK = {6'd31, 6'd15, 6'd7, 6'd3};

  // Feedback taps for a maximal length 8-bit Galois LFSR
  localparam logic [LFSR_WIDTH-1:0] LFSR_POLY = 8'hB8;

endpackage

// File: source/instr_fifo.sv
////////////////////////////////////////////////////////////
// Instruction FIFO between fetch and decode
// Circular buffer with wrap bit pointers
// Accepts a write while full if a read happens in the same cycle
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module instr_fifo
  import dummy_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  logic   clk,
  input  logic   rst_n,
  // Write side
  input  logic   wr_valid_i,
  output logic   wr_ready_o,
  input  instr_t wr_instr_i,
  // Read side
  output logic   rd_valid_o,
  input  logic   rd_ready_i,
  output instr_t rd_instr_o
);

  localparam int AW = $clog2(FIFO_DEPTH);

  instr_t        mem [FIFO_DEPTH];
  logic [AW:0]   wr_ptr_q;
  logic [AW:0]   rd_ptr_q;
  logic          full;
  logic          empty;
  logic          wr_fire;
  logic          rd_fire;

  // Equal addresses with different wrap bits mean the buffer is full
  assign empty = (wr_ptr_q == rd_ptr_q);
  assign full  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                 (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

  // A full buffer still takes a write when the head leaves in the same cycle
  assign wr_ready_o = !full || rd_ready_i;
  assign rd_valid_o = !empty;
  assign rd_instr_o = mem[rd_ptr_q[AW-1:0]];

  assign wr_fire = wr_valid_i && wr_ready_o;
  assign rd_fire = rd_valid_o && rd_ready_i;

  // Storage
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[wr_ptr_q[AW-1:0]] <= wr_instr_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

endmodule

// File: testbench/dummy_insert_checker.sv
////////////////////////////////////////////////////////////
// Concurrent assertions for the insertion controller
// Count against the LFSR threshold and the fetch stall
// Bound into every dummy_insert_ctrl instance
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dummy_insert_checker #(
  parameter int CNT_WIDTH = 7
) (
  input logic                 clk,
  input logic                 rst_n,
  input logic [CNT_WIDTH-1:0] cnt_q_i,
  input logic [5:0]           lfsr_cnt_i,
  input logic                 insert_pending_i,
  input logic                 hint_fire_i,
  input logic                 fetch_ready_i
);

  logic [CNT_WIDTH-1:0] first_over;

  // Smallest count that lies above the current threshold
  assign first_over = CNT_WIDTH'(lfsr_cnt_i) + CNT_WIDTH'(1);

  // Plain instructions raise the count one step at a time
  count_at_insert_a: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(insert_pending_i) && !$past(hint_fire_i) |-> cnt_q_i == first_over)
    else $error("Insertion began at count %0d instead of %0d", cnt_q_i, first_over);

  // A hint moves the threshold, so the count may already be further above it
  // The hint itself still has to advance the count by exactly one
  count_after_hint_a: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(insert_pending_i) && $past(hint_fire_i) |->
      cnt_q_i >= first_over && cnt_q_i == $past(cnt_q_i) + CNT_WIDTH'(1))
    else $error("Insertion after a hint began without the hint being counted");

  // Above the threshold only a dummy transfer may change the count
  count_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q_i > CNT_WIDTH'(lfsr_cnt_i) |=> cnt_q_i <= $past(cnt_q_i))
    else $error("Instruction count grew while a dummy was pending");

  // Fetch stays stalled while a dummy waits for the FIFO
  fetch_stall_a: assert property (@(posedge clk) disable iff (!rst_n)
    insert_pending_i |-> !fetch_ready_i)
    else $error("Fetch was ready while a dummy was pending");

endmodule

bind dummy_insert_ctrl dummy_insert_checker #(
  .CNT_WIDTH (CNT_WIDTH)
) ctrl_checker_i (
  .clk              (clk),
  .rst_n            (rst_n),
  .cnt_q_i          (cnt_q),
  .lfsr_cnt_i       (lfsr_cnt_i),
  .insert_pending_i (insert_pending),
  .hint_fire_i      (hint_fire),
  .fetch_ready_i    (fetch_ready_o)
);

// File: testbench/dummy_insert_tb.sv
////////////////////////////////////////////////////////////
// Testbench for the dummy instruction insertion path
// Clock, reset and LCG stimulus with a software LFSR model
// Result comparison, dummy count checks and a cycle limit
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dummy_insert_tb
  import dummy_pkg::*;
();

  localparam logic [LFSR_WIDTH-1:0] LFSR_SEED = 8'h5A;
  localparam int N_PLAIN     = 200;
  localparam int N_FREQ      = 60;
  localparam int N_HINT      = 120;
  localparam int N_BP        = 200;
  localparam int TOTAL_INSTR = N_PLAIN + 4 * N_FREQ + N_HINT + N_BP;
  localparam int CYCLE_LIMIT = 20 * TOTAL_INSTR + 200;

  logic                       clk;
  logic                       rst_n;
  xsecure_ctrl_t              xsecure_ctrl_i;
  logic                       fetch_valid_i;
  logic                       fetch_ready_o;
  instr_t                     fetch_instr_i;
  logic                       res_valid_o;
  logic                       res_ready_i;
  result_t                    res_o;
  logic [DUMMY_CNT_WIDTH-1:0] dummy_count_o;

  // Stimulus and model state
  logic [31:0]           lcg_state;
  logic [LFSR_WIDTH-1:0] model_lfsr;
  int                    model_cnt;
  int                    model_dummies;
  result_t               exp_q[$];
  instr_t                instr_q[$];
  int                    gap_q[$];
  string                 test_name;
  logic                  bp_active;
  int                    cycle_count;
  int                    result_errors;
  int                    count_errors;
  int                    protocol_errors;

  dummy_insert_top #(
    .FIFO_DEPTH (4),
    .CNT_WIDTH  (7),
    .LFSR_SEED  (LFSR_SEED)
  ) dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .xsecure_ctrl_i (xsecure_ctrl_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_ready_o  (fetch_ready_o),
    .fetch_instr_i  (fetch_instr_i),
    .res_valid_o    (res_valid_o),
    .res_ready_i    (res_ready_i),
    .res_o          (res_o),
    .dummy_count_o  (dummy_count_o)
  );

  always #5 clk = ~clk;

  always @(posedge clk) cycle_count <= cycle_count + 1;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // The upper half of the LCG state has the longest period
  function automatic logic [15:0] lcg_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  // One Galois step, taps folded in when a one drops out
  function automatic logic [LFSR_WIDTH-1:0] lfsr_step(input logic [LFSR_WIDTH-1:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_POLY) : (s >> 1);
  endfunction

  // Expected ALU result of a real instruction
  function automatic result_t alu_ref(input instr_t instr);
    result_t res;
    res.opcode = instr.opcode;
    case (instr.opcode)
      OP_ADD:  res.value = instr.operand_a + instr.operand_b;
      OP_SUB:  res.value = instr.operand_a - instr.operand_b;
      OP_XOR:  res.value = instr.operand_a ^ instr.operand_b;
      OP_AND:  res.value = instr.operand_a & instr.operand_b;
      default: res.value = instr.operand_a;
    endcase
    return res;
  endfunction

  // Hints appear with a chance of one in hint_div when hint_div is nonzero
  function automatic instr_t make_instr(input int hint_div);
    instr_t      instr;
    logic [15:0] rnd;
    rnd = lcg_rand();
    instr.opcode = opcode_e'({1'b0, rnd[9:8]});
    if (hint_div > 0 && (int'(rnd[7:0]) % hint_div) == 0) begin
      instr.opcode = OP_HINT;
    end
    instr.operand_a = lcg_rand();
    instr.operand_b = lcg_rand();
    // Fetched words may carry a stray dummy bit that the DUT has to clear
    instr.is_dummy = rnd[12];
    return instr;
  endfunction

  // Tracks the interval counter and places a dummy right after the instruction
  // that pushes the count past the masked LFSR threshold
  function automatic void model_accept(input instr_t instr);
    logic [5:0] threshold;
    if (xsecure_ctrl_i.dummy_en) begin
      model_cnt++;
    end else begin
      model_cnt = 0;
    end
    if (instr.opcode == OP_HINT) begin
      model_lfsr = lfsr_step(model_lfsr);
    end
    threshold = model_lfsr[5:0] & FREQ_MASK[xsecure_ctrl_i.dummy_freq];
    if (xsecure_ctrl_i.dummy_en && model_cnt > int'(threshold)) begin
      model_dummies++;
      model_cnt  = 0;
      model_lfsr = lfsr_step(model_lfsr);
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus tasks, entered 1 ns after a rising edge
  ////////////////////////////////////////////////////////////

  task automatic set_config(input logic en, input logic [1:0] freq);
    // One edge with the enable low clears the DUT counter
    xsecure_ctrl_i.dummy_en = 1'b0;
    @(posedge clk);
    #1;
    xsecure_ctrl_i.dummy_freq = freq;
    xsecure_ctrl_i.dummy_en   = en;
    model_cnt = 0;
  endtask

  // Holds valid and data until the edge that sees ready high
  task automatic send_instr(input instr_t instr);
    logic accepted;
    fetch_valid_i = 1'b1;
    fetch_instr_i = instr;
    do begin
      @(negedge clk);
      accepted = fetch_ready_o;
      @(posedge clk);
      #1;
    end while (!accepted);
    fetch_valid_i = 1'b0;
  endtask

  // Idle means every result is back and no dummy is pending or buffered
  task automatic wait_idle();
    do begin
      @(negedge clk);
    end while (exp_q.size() != 0 || !fetch_ready_o || dut_i.buf_valid || res_valid_o);
  endtask

  task automatic run_test(input string name, input logic en, input logic [1:0] freq,
                          input int count, input int hint_div, input logic use_bp);
    instr_t      instr;
    logic [15:0] rnd;
    int          gap;
    test_name = name;
    set_config(en, freq);
    // The whole sequence and its expected outcome are known before sending
    for (int i = 0; i < count; i++) begin
      instr = make_instr(hint_div);
      rnd   = lcg_rand();
      instr_q.push_back(instr);
      gap_q.push_back(use_bp ? int'(rnd[1:0]) : 0);
      model_accept(instr);
      if (instr.opcode != OP_HINT) begin
        exp_q.push_back(alu_ref(instr));
      end
    end
    if (use_bp) begin
      @(negedge clk);
      bp_active = 1'b1;
      @(posedge clk);
      #1;
    end
    while (instr_q.size() > 0) begin
      gap = gap_q.pop_front();
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      send_instr(instr_q.pop_front());
    end
    wait_idle();
    bp_active = 1'b0;
    if (dummy_count_o !== DUMMY_CNT_WIDTH'(model_dummies)) begin
      $display("[ERROR] %s: expected dummy count %0d, actual %0d",
               test_name, model_dummies, dummy_count_o);
      count_errors++;
    end
    @(posedge clk);
    #1;
  endtask

  ////////////////////////////////////////////////////////////
  // Result side and comparison
  ////////////////////////////////////////////////////////////

  initial begin : result_side
    logic [15:0] rnd;
    result_t     expected;
    @(posedge rst_n);
    forever begin
      @(posedge clk);
      #1;
      if (bp_active) begin
        rnd         = lcg_rand();
        res_ready_i = rnd[5];
      end else begin
        res_ready_i = 1'b1;
      end
      // A transfer takes place at the coming edge
      @(negedge clk);
      if (res_valid_o && res_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("A result arrived in %s with no real instruction outstanding", test_name);
          protocol_errors++;
        end else begin
          expected = exp_q.pop_front();
          if (res_o !== expected) begin
            $display("[ERROR] %s: expected opcode %0d value %h, actual opcode %0d value %h",
                     test_name, expected.opcode, expected.value, res_o.opcode, res_o.value);
            result_errors++;
          end
        end
      end
    end
  end

  initial begin : watchdog
    wait (cycle_count >= CYCLE_LIMIT);
    $display("The run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Errors: results %0d, dummy counts %0d, protocol %0d",
             result_errors, count_errors, protocol_errors);
    $display("Testbench failed");
    $finish;
  end

  initial begin : main_sequence
    clk             = 1'b0;
    rst_n           = 1'b0;
    xsecure_ctrl_i  = '0;
    fetch_valid_i   = 1'b0;
    fetch_instr_i   = '0;
    res_ready_i     = 1'b0;
    lcg_state       = 32'd6;
    model_lfsr      = LFSR_SEED;
    model_cnt       = 0;
    model_dummies   = 0;
    bp_active       = 1'b0;
    cycle_count     = 0;
    result_errors   = 0;
    count_errors    = 0;
    protocol_errors = 0;
    test_name       = "reset";
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    if (!fetch_ready_o || res_valid_o || dummy_count_o !== '0) begin
      $display("Outputs are not idle after reset");
      protocol_errors++;
    end
    @(posedge clk);
    #1;
    run_test("no_dummy", 1'b0, 2'd0, N_PLAIN, 0, 1'b0);
    run_test("freq_0", 1'b1, 2'd0, N_FREQ, 0, 1'b0);
    run_test("freq_1", 1'b1, 2'd1, N_FREQ, 0, 1'b0);
    run_test("freq_2", 1'b1, 2'd2, N_FREQ, 0, 1'b0);
    run_test("freq_3", 1'b1, 2'd3, N_FREQ, 0, 1'b0);
    run_test("hint_mix", 1'b1, 2'd1, N_HINT, 4, 1'b0);
    run_test("back_pressure", 1'b1, 2'd0, N_BP, 8, 1'b1);
    $display("Errors: results %0d, dummy counts %0d, protocol %0d",
             result_errors, count_errors, protocol_errors);
    if (result_errors + count_errors + protocol_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
